//--- verilog.f
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/main_cache.sv
verilog/victim_cache.sv
verilog/mshr_table.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/mem_responder.sv
test/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb -f verilog.f -o Vdcache_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

//--- test/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_RANDOM    = 300;
    localparam int N_DIRECTED  = 60;
    localparam int MISS_WORST  = 40;  // two write-backs, a load and a fill delay
    localparam int CYCLE_LIMIT = (N_RANDOM + N_DIRECTED) * MISS_WORST * 2;

    logic                     clock;
    logic                     reset;
    logic                     req_valid;
    mem_op_e                  req_op;
    mem_size_e                req_size;
    logic [`XLEN-1:0]         req_addr;
    logic [`XLEN-1:0]         req_wdata;
    logic                     stall;
    logic                     resp_valid;
    logic [`XLEN-1:0]         resp_data;
    mem_cmd_e                 mem_command;
    logic [`XLEN-1:0]         mem_addr;
    logic [`BLK_BITS-1:0]     mem_wdata;
    logic [`MEM_TAG_BITS-1:0] mem_response;
    logic [`MEM_TAG_BITS-1:0] mem_tag;
    logic [`BLK_BITS-1:0]     mem_rdata;

    logic [7:0]  model [4096];    // byte memory as the pipeline sees it
    logic [31:0] rng;
    logic        check_wb;        // compare write-back data with the model
    logic [31:0] last_load_addr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          loads_seen = 0;
    int          stores_seen = 0;

    dcache_top u_dcache_top (
        .clock, .reset,
        .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .stall, .resp_valid, .resp_data,
        .mem_command, .mem_addr, .mem_wdata, .mem_response, .mem_tag, .mem_rdata
    );

    mem_responder u_mem_responder (
        .clock, .reset,
        .mem_command, .mem_addr, .mem_wdata, .mem_response, .mem_tag, .mem_rdata
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [7:0] init_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] model_load(input mem_size_e size, input logic [11:0] a);
        case (size)
            SIZE_BYTE: return {24'b0, model[a]};
            SIZE_HALF: return {16'b0, model[a + 12'd1], model[a]};
            default:   return {model[a + 12'd3], model[a + 12'd2], model[a + 12'd1], model[a]};
        endcase
    endfunction

    task automatic model_store(input mem_size_e size, input logic [11:0] a,
                               input logic [31:0] wdata);
        int n;
        n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++)
            model[a + 12'(i)] = wdata[8*i +: 8];
    endtask

    function automatic logic [63:0] model_line(input logic [11:0] a);
        logic [63:0] line;
        for (int i = 0; i < 8; i++)
            line[8*i +: 8] = model[{a[11:3], 3'b0} + 12'(i)];
        return line;
    endfunction

    // one request, waits for resp_valid and returns the latency in cycles
    task automatic access(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                          input logic [31:0] wdata, output int lat);
        logic [31:0] exp;
        int          n;
        @(posedge clock);
        req_valid <= 1'b1;
        req_op    <= op;
        req_size  <= size;
        req_addr  <= addr;
        req_wdata <= wdata;
        exp = model_load(size, addr[11:0]);
        if (op == MEM_WRITE)
            model_store(size, addr[11:0], wdata);
        @(posedge clock);          // request taken at this edge
        req_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n == 1 && !resp_valid)
                check_value(64'(stall), 64'd1, "stall after a miss");
        end while (!resp_valid);
        check_value(64'(stall), 64'd0, "stall low with resp_valid");
        if (op == MEM_READ)
            check_value(64'(resp_data), 64'(exp), $sformatf("load data at %h", addr));
        lat = n;
    endtask

    // accepted memory commands are decided at the next rising edge
    always @(negedge clock) begin
        if (!reset && mem_command != CMD_NONE && mem_response != '0) begin
            if (mem_command == CMD_LOAD) begin
                loads_seen++;
                last_load_addr = mem_addr;
            end else begin
                stores_seen++;
                if (check_wb)
                    check_value(mem_wdata, model_line(mem_addr[11:0]), "write-back line");
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic report(input int num, input string name, input int errs_before);
        $display("test %0d %s done, %0d errors", num, name, errors - errs_before);
    endtask

    initial begin
        int          lat;
        int          e0;
        int          loads0;
        int          stores0;
        logic [31:0] r;
        logic [31:0] a;
        mem_size_e   sz;

        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = MEM_READ;
        req_size  = SIZE_WORD;
        req_addr  = '0;
        req_wdata = '0;
        check_wb  = 1'b0;
        rng       = 32'hc41;
        for (int i = 0; i < 4096; i++)
            model[i] = init_byte(12'(i));
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // stores of each size, then loads from the same line
        e0 = errors;
        access(MEM_WRITE, SIZE_BYTE, 32'h041, 32'h0000_00a5, lat);
        access(MEM_WRITE, SIZE_HALF, 32'h042, 32'h0000_b7c3, lat);
        access(MEM_WRITE, SIZE_WORD, 32'h044, 32'hdead_beef, lat);
        access(MEM_READ, SIZE_BYTE, 32'h041, 32'h0, lat);
        check_value(64'(lat), 64'd1, "byte load hit latency");
        access(MEM_READ, SIZE_HALF, 32'h042, 32'h0, lat);
        check_value(64'(lat), 64'd1, "half load hit latency");
        access(MEM_READ, SIZE_WORD, 32'h044, 32'h0, lat);
        check_value(64'(lat), 64'd1, "word load hit latency");
        access(MEM_READ, SIZE_WORD, 32'h040, 32'h0, lat);
        access(MEM_READ, SIZE_BYTE, 32'h043, 32'h0, lat);
        report(1, "store/load sizes", e0);

        // cold load fetches its line once
        e0 = errors;
        loads0 = loads_seen;
        access(MEM_READ, SIZE_WORD, 32'h104, 32'h0, lat);
        check_value(64'(lat > 1), 64'd1, "cold load stalls");
        check_value(64'(loads_seen - loads0), 64'd1, "load commands for cold line");
        check_value(64'(last_load_addr), 64'h100, "load command address");
        report(2, "cold miss", e0);

        // two lines on one index ping-pong through the victim cache
        e0 = errors;
        access(MEM_READ, SIZE_WORD, 32'h200, 32'h0, lat);
        access(MEM_READ, SIZE_WORD, 32'h280, 32'h0, lat);
        loads0 = loads_seen;
        for (int i = 0; i < 6; i++) begin
            access(MEM_READ, SIZE_WORD, (i % 2 == 0) ? 32'h200 : 32'h280, 32'h0, lat);
            check_value(64'(lat), 64'd1, "victim hit latency");
        end
        check_value(64'(loads_seen - loads0), 64'd0, "load commands during ping-pong");
        report(3, "victim hits", e0);

        // eight dirty lines on index 5 force write-backs
        e0 = errors;
        check_wb = 1'b1;
        stores0  = stores_seen;
        for (int k = 0; k < 8; k++)
            access(MEM_WRITE, SIZE_WORD, 32'h828 + 32'(k) * 32'h80, next_rand(), lat);
        for (int k = 0; k < 8; k++)
            access(MEM_READ, SIZE_WORD, 32'h828 + 32'(k) * 32'h80, 32'h0, lat);
        check_value(64'(stores_seen - stores0 >= 3), 64'd1, "write-back count");
        check_wb = 1'b0;
        report(4, "dirty write-back", e0);

        // random mix over 1 KB
        e0 = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = next_rand();
            sz = (r[2:1] == 2'd3) ? SIZE_WORD : mem_size_e'(r[2:1]);
            a  = {22'b0, r[12:3]};
            if (sz == SIZE_HALF)
                a[0] = 1'b0;
            else if (sz == SIZE_WORD)
                a[1:0] = 2'b00;
            access(r[0] ? MEM_WRITE : MEM_READ, sz, a, next_rand(), lat);
        end
        report(5, "random mix", e0);

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- test/mem_responder.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module mem_responder (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::mem_cmd_e     mem_command,
    input  logic [`XLEN-1:0]         mem_addr,
    input  logic [`BLK_BITS-1:0]     mem_wdata,
    output logic [`MEM_TAG_BITS-1:0] mem_response,
    output logic [`MEM_TAG_BITS-1:0] mem_tag,
    output logic [`BLK_BITS-1:0]     mem_rdata
);
    import dcache_pkg::*;

    logic [7:0]               mem [4096];
    logic [31:0]              rng;
    logic [`MEM_TAG_BITS-1:0] tag_next;   // tag offered for the next accept
    logic                     pend;       // one load in flight at most
    logic [`MEM_TAG_BITS-1:0] pend_tag;
    logic [11:0]              pend_addr;
    int                       pend_wait;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // same fill pattern as the testbench model over all 12 address bits
    function automatic logic [7:0] init_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    function automatic logic [63:0] read_line(input logic [11:0] a);
        logic [63:0] line;
        for (int i = 0; i < 8; i++)
            line[8*i +: 8] = mem[a + 12'(i)];
        return line;
    endfunction

    initial begin
        rng = 32'hc41;
        mem_response <= '0;
        mem_tag      <= '0;
        mem_rdata    <= '0;
        for (int i = 0; i < 4096; i++)
            mem[i] = init_byte(12'(i));
    end

    always @(posedge clock) begin
        rng = xorshift(rng);
        if (reset) begin
            mem_response <= '0;
            mem_tag      <= '0;
            mem_rdata    <= '0;
            pend         <= 1'b0;
            tag_next     = 4'd1;
        end else begin
            mem_tag <= '0;
            if (mem_command != CMD_NONE && mem_response != '0) begin
                if (mem_command == CMD_STORE) begin
                    for (int i = 0; i < 8; i++)
                        mem[mem_addr[11:0] + 12'(i)] = mem_wdata[8*i +: 8];
                end else begin
                    pend      <= 1'b1;
                    pend_tag  <= mem_response;
                    pend_addr <= mem_addr[11:0];
                    pend_wait <= int'(rng[2:0]);  // 0 to 7 extra cycles
                end
                tag_next = (tag_next == 4'd15) ? 4'd1 : tag_next + 4'd1;
            end
            if (pend) begin
                if (pend_wait == 0) begin
                    mem_tag   <= pend_tag;
                    mem_rdata <= read_line(pend_addr);
                    pend      <= 1'b0;
                end else begin
                    pend_wait <= pend_wait - 1;
                end
            end
            mem_response <= (rng[7:4] < 4'd11) ? tag_next : '0; // back-pressure
        end
    end

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  dcache_pkg::mem_op_e           req_op,
    input  dcache_pkg::mem_size_e         req_size,
    input  logic [`XLEN-1:0]              req_addr,
    input  logic [`XLEN-1:0]              req_wdata,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [`XLEN-1:0]              resp_data,
    output dcache_pkg::mem_cmd_e          mem_command,
    output logic [`XLEN-1:0]              mem_addr,
    output logic [`BLK_BITS-1:0]          mem_wdata,
    input  logic [`MEM_TAG_BITS-1:0]      mem_response,
    input  logic [`MEM_TAG_BITS-1:0]      mem_tag,
    input  logic [`BLK_BITS-1:0]          mem_rdata
);

    cache_req_if req_main();
    cache_req_if req_vc();
    line_xfer_if evict_main(); // main cache -> victim cache
    line_xfer_if evict_vc();   // dirty victim -> miss table

    logic                       miss_alloc;
    logic [`LINE_ADDR_BITS-1:0] miss_line_addr;
    logic                       fill_valid;
    logic [`LINE_ADDR_BITS-1:0] fill_line_addr;
    logic [`BLK_BITS-1:0]       fill_block;

    dcache_ctrl u_dcache_ctrl (
        .clock, .reset,
        .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .stall, .resp_valid, .resp_data,
        .req_main, .req_vc,
        .fill_valid, .fill_block,
        .miss_alloc, .miss_line_addr
    );

    main_cache u_main_cache (
        .clock, .reset,
        .req(req_main),
        .fill_valid, .fill_line_addr, .fill_block,
        .evict(evict_main)
    );

    victim_cache u_victim_cache (
        .clock, .reset,
        .req(req_vc),
        .in_line(evict_main),
        .wb(evict_vc)
    );

    mshr_table u_mshr_table (
        .clock, .reset,
        .miss_alloc, .miss_line_addr,
        .wb(evict_vc),
        .mem_command, .mem_addr, .mem_wdata, .mem_response, .mem_tag, .mem_rdata,
        .fill_valid, .fill_line_addr, .fill_block
    );

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  dcache_pkg::mem_op_e         req_op,
    input  dcache_pkg::mem_size_e       req_size,
    input  logic [`XLEN-1:0]            req_addr,
    input  logic [`XLEN-1:0]            req_wdata,
    output logic                        stall,
    output logic                        resp_valid,
    output logic [`XLEN-1:0]            resp_data,
    cache_req_if.ctrl                   req_main,
    cache_req_if.ctrl                   req_vc,
    input  logic                        fill_valid,
    input  logic [`BLK_BITS-1:0]        fill_block,
    output logic                        miss_alloc,
    output logic [`LINE_ADDR_BITS-1:0]  miss_line_addr
);
    import dcache_pkg::*;

    ctrl_state_e      state;
    mem_op_e          held_op;   // request waiting on the fill
    mem_size_e        held_size;
    logic [`XLEN-1:0] held_addr;
    logic [`XLEN-1:0] held_wdata;

    logic             replaying;
    logic             acc_valid;
    mem_op_e          acc_op;
    mem_size_e        acc_size;
    logic [`XLEN-1:0] acc_addr;
    logic [`XLEN-1:0] acc_wdata;
    logic             any_hit;
    cache_block_t     hit_block;

    assign stall     = (state != ST_READY);
    assign replaying = (state == ST_REPLAY);

    // in wait_mem nothing is applied to the caches
    assign acc_valid = (state == ST_READY && req_valid) || replaying;
    assign acc_op    = replaying ? held_op    : req_op;
    assign acc_size  = replaying ? held_size  : req_size;
    assign acc_addr  = replaying ? held_addr  : req_addr;
    assign acc_wdata = replaying ? held_wdata : req_wdata;

    // both caches see the same access
    assign req_main.valid = acc_valid;
    assign req_main.op    = acc_op;
    assign req_main.size  = acc_size;
    assign req_main.addr  = acc_addr;
    assign req_main.wdata = acc_wdata;
    assign req_vc.valid   = acc_valid;
    assign req_vc.op      = acc_op;
    assign req_vc.size    = acc_size;
    assign req_vc.addr    = acc_addr;
    assign req_vc.wdata   = acc_wdata;

    assign any_hit   = req_main.hit | req_vc.hit;
    assign hit_block = req_main.hit ? req_main.hit_block : req_vc.hit_block;

    assign miss_alloc     = (state == ST_READY) && req_valid && !any_hit;
    assign miss_line_addr = req_addr[`XLEN-1:`BLK_OFS];

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ST_READY;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= acc_valid && any_hit; // replay always hits main
            case (state)
                ST_READY:    if (miss_alloc) state <= ST_WAIT_MEM;
                ST_WAIT_MEM: if (fill_valid) state <= ST_REPLAY;
                default:     state <= ST_READY;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (miss_alloc) begin
            held_op    <= req_op;
            held_size  <= req_size;
            held_addr  <= req_addr;
            held_wdata <= req_wdata;
        end
        if (acc_valid && any_hit)
            resp_data <= load_extract(hit_block, acc_size, acc_addr[`BLK_OFS-1:0]);
    end

    // lines are exclusive between the two caches
    a_no_double_hit: assert property (@(posedge clock) disable iff (reset)
        !(req_main.hit && req_vc.hit));

    a_aligned: assert property (@(posedge clock) disable iff (reset)
        acc_valid |-> (acc_size == SIZE_BYTE) ||
                      (acc_size == SIZE_HALF && !acc_addr[0]) ||
                      (acc_size == SIZE_WORD && acc_addr[1:0] == 2'b00));

    // the filled line is in main and unchanged when the replay looks it up
    a_replay_hits_fill: assert property (@(posedge clock) disable iff (reset)
        (state == ST_WAIT_MEM && fill_valid) |=>
            (req_main.hit && req_main.hit_block == $past(fill_block)));

endmodule

//--- verilog/mshr_table.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module mshr_table (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        miss_alloc,
    input  logic [`LINE_ADDR_BITS-1:0]  miss_line_addr,
    line_xfer_if.sink                   wb,
    output dcache_pkg::mem_cmd_e        mem_command,
    output logic [`XLEN-1:0]            mem_addr,
    output logic [`BLK_BITS-1:0]        mem_wdata,
    input  logic [`MEM_TAG_BITS-1:0]    mem_response,
    input  logic [`MEM_TAG_BITS-1:0]    mem_tag,
    input  logic [`BLK_BITS-1:0]        mem_rdata,
    output logic                        fill_valid,
    output logic [`LINE_ADDR_BITS-1:0]  fill_line_addr,
    output logic [`BLK_BITS-1:0]        fill_block
);
    import dcache_pkg::*;

    localparam int M_IDX = $clog2(`N_MSHR);

    logic [`N_MSHR-1:0]         e_valid;
    logic [`N_MSHR-1:0]         e_issued;  // accepted load, waiting for data
    mem_op_e                    e_op    [`N_MSHR];
    logic [`MEM_TAG_BITS-1:0]   e_tag   [`N_MSHR];
    logic [`LINE_ADDR_BITS-1:0] e_addr  [`N_MSHR];
    logic [`BLK_BITS-1:0]       e_block [`N_MSHR];

    logic [`N_MSHR-1:0] is_load;
    logic               sel_found;
    logic [M_IDX-1:0]   sel_idx;
    logic [M_IDX-1:0]   resp_idx;
    logic [M_IDX-1:0]   free_idx;
    logic               accept;
    logic               wb_take;
    logic               alloc;

    always_comb begin
        sel_found  = 1'b0;
        sel_idx    = '0;
        fill_valid = 1'b0;
        resp_idx   = '0;
        free_idx   = '0;
        for (int i = `N_MSHR - 1; i >= 0; i--) begin
            is_load[i] = e_valid[i] && (e_op[i] == MEM_READ);
            if (!e_valid[i])
                free_idx = M_IDX'(i);
            if (is_load[i] && !e_issued[i]) begin
                sel_found = 1'b1;
                sel_idx   = M_IDX'(i);
            end
            if (is_load[i] && e_issued[i] && mem_tag != '0 && e_tag[i] == mem_tag) begin
                fill_valid = 1'b1;
                resp_idx   = M_IDX'(i);
            end
        end
        // pending write-backs go out ahead of the load
        for (int i = `N_MSHR - 1; i >= 0; i--) begin
            if (e_valid[i] && e_op[i] == MEM_WRITE) begin
                sel_found = 1'b1;
                sel_idx   = M_IDX'(i);
            end
        end
    end

    assign mem_command = !sel_found ? CMD_NONE :
                         (e_op[sel_idx] == MEM_WRITE) ? CMD_STORE : CMD_LOAD;
    assign mem_addr    = {e_addr[sel_idx], {`BLK_OFS{1'b0}}};
    assign mem_wdata   = e_block[sel_idx];
    assign accept      = sel_found && (mem_response != '0);

    assign fill_line_addr = e_addr[resp_idx];
    assign fill_block     = mem_rdata;

    assign wb_take = wb.valid && wb.dirty;
    assign alloc   = miss_alloc || wb_take;

    always_ff @(posedge clock) begin
        if (reset) begin
            e_valid  <= '0;
            e_issued <= '0;
        end else begin
            if (accept) begin
                if (e_op[sel_idx] == MEM_WRITE)
                    e_valid[sel_idx] <= 1'b0; // store done once accepted
                else
                    e_issued[sel_idx] <= 1'b1;
            end
            if (fill_valid)
                e_valid[resp_idx] <= 1'b0;
            if (alloc) begin
                e_valid[free_idx]  <= 1'b1;
                e_issued[free_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept)
            e_tag[sel_idx] <= mem_response;
        if (alloc) begin
            e_op[free_idx]    <= wb_take ? MEM_WRITE : MEM_READ;
            e_addr[free_idx]  <= wb_take ? wb.line_addr : miss_line_addr;
            e_block[free_idx] <= wb.block;
        end
    end

    a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !(&e_valid));

    a_one_load: assert property (@(posedge clock) disable iff (reset)
        $countones(is_load) <= 1);

endmodule

//--- verilog/victim_cache.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module victim_cache (
    input  logic        clock,
    input  logic        reset,
    cache_req_if.cache  req,
    line_xfer_if.sink   in_line,
    line_xfer_if.source wb
);
    import dcache_pkg::*;

    localparam int VC_IDX = $clog2(`N_VC);

    logic [`N_VC-1:0]           vc_valid;
    logic [`N_VC-1:0]           vc_dirty;
    logic [`LINE_ADDR_BITS-1:0] vc_addr  [`N_VC];
    cache_block_t               vc_block [`N_VC];
    logic [`LRU_BITS-1:0]       vc_lru   [`N_VC];

    logic [`N_VC-1:0]     match;
    logic [VC_IDX-1:0]    hit_idx;
    logic [VC_IDX-1:0]    ins_idx;
    logic [VC_IDX-1:0]    touch_idx;
    logic                 has_free;
    logic [`LRU_BITS-1:0] min_lru;
    logic                 store_hit;

    // full associative search by line address
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < `N_VC; i++) begin
            match[i] = vc_valid[i] && (vc_addr[i] == req.addr[`XLEN-1:`BLK_OFS]);
            if (match[i])
                hit_idx = VC_IDX'(i);
        end
    end

    // first free slot, else oldest (lowest index on ties)
    always_comb begin
        has_free = 1'b0;
        ins_idx  = '0;
        min_lru  = vc_lru[0];
        for (int i = `N_VC - 1; i >= 0; i--) begin
            if (!vc_valid[i]) begin
                has_free = 1'b1;
                ins_idx  = VC_IDX'(i);
            end
        end
        if (!has_free) begin
            for (int i = 1; i < `N_VC; i++) begin
                if (vc_lru[i] < min_lru) begin
                    min_lru = vc_lru[i];
                    ins_idx = VC_IDX'(i);
                end
            end
        end
    end

    assign req.hit       = req.valid && (|match);
    assign req.hit_block = vc_block[hit_idx];
    assign store_hit     = req.hit && (req.op == MEM_WRITE);
    assign touch_idx     = in_line.valid ? ins_idx : hit_idx;

    // only a displaced dirty line needs writing back
    assign wb.valid     = in_line.valid && !has_free && vc_dirty[ins_idx];
    assign wb.line_addr = vc_addr[ins_idx];
    assign wb.block     = vc_block[ins_idx];
    assign wb.dirty     = vc_dirty[ins_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            vc_valid <= '0;
            vc_dirty <= '0;
            for (int i = 0; i < `N_VC; i++)
                vc_lru[i] <= '0;
        end else begin
            if (in_line.valid) begin
                vc_valid[ins_idx] <= 1'b1;
                vc_dirty[ins_idx] <= in_line.dirty;
            end else if (store_hit) begin
                vc_dirty[hit_idx] <= 1'b1;
            end
            if (in_line.valid || req.hit) begin
                for (int i = 0; i < `N_VC; i++) begin
                    if (VC_IDX'(i) == touch_idx)
                        vc_lru[i] <= '1;         // most recent
                    else if (vc_lru[i] != '0)
                        vc_lru[i] <= vc_lru[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_line.valid) begin
            vc_addr[ins_idx]  <= in_line.line_addr;
            vc_block[ins_idx] <= in_line.block;
        end else if (store_hit) begin
            vc_block[hit_idx] <= store_merge(vc_block[hit_idx], mem_size_e'(req.size),
                                             req.addr[`BLK_OFS-1:0], req.wdata);
        end
    end

    a_single_match: assert property (@(posedge clock) disable iff (reset)
        $onehot0(match));

endmodule

//--- verilog/main_cache.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module main_cache (
    input  logic                        clock,
    input  logic                        reset,
    cache_req_if.cache                  req,
    input  logic                        fill_valid,
    input  logic [`LINE_ADDR_BITS-1:0]  fill_line_addr,
    input  logic [`BLK_BITS-1:0]        fill_block,
    line_xfer_if.source                 evict
);
    import dcache_pkg::*;

    logic [`N_CL-1:0]     line_valid;
    logic [`N_CL-1:0]     line_dirty;
    logic [`TAG_BITS-1:0] line_tag   [`N_CL];
    cache_block_t         line_block [`N_CL];

    logic [`IDX_BITS-1:0] req_idx;
    logic [`IDX_BITS-1:0] fill_idx;
    logic                 store_hit;

    assign req_idx  = req.addr[`IDX_BITS+`BLK_OFS-1:`BLK_OFS];
    assign fill_idx = fill_line_addr[`IDX_BITS-1:0];

    assign req.hit = req.valid && line_valid[req_idx] &&
                     (line_tag[req_idx] == req.addr[`XLEN-1 -: `TAG_BITS]);
    assign req.hit_block = line_block[req_idx];
    assign store_hit     = req.hit && (req.op == MEM_WRITE);

    // the line displaced by a fill goes to the victim cache
    assign evict.valid     = fill_valid && line_valid[fill_idx];
    assign evict.line_addr = {line_tag[fill_idx], fill_idx};
    assign evict.block     = line_block[fill_idx];
    assign evict.dirty     = line_dirty[fill_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (fill_valid) begin
            line_valid[fill_idx] <= 1'b1;
            line_dirty[fill_idx] <= 1'b0; // fresh from memory
        end else if (store_hit) begin
            line_dirty[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_tag[fill_idx]   <= fill_line_addr[`LINE_ADDR_BITS-1:`IDX_BITS];
            line_block[fill_idx] <= fill_block;
        end else if (store_hit) begin
            line_block[req_idx] <= store_merge(line_block[req_idx], mem_size_e'(req.size),
                                               req.addr[`BLK_OFS-1:0], req.wdata);
        end
    end

endmodule

//--- verilog/dcache_ifs.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

// one access presented to a cache, and the lookup result coming back
interface cache_req_if;
    logic                 valid;     // apply this access now
    logic                 op;        // 1 for store
    logic [1:0]           size;
    logic [`XLEN-1:0]     addr;
    logic [`XLEN-1:0]     wdata;
    logic                 hit;
    logic [`BLK_BITS-1:0] hit_block;

    modport ctrl  (output valid, op, size, addr, wdata, input hit, hit_block);
    modport cache (input valid, op, size, addr, wdata, output hit, hit_block);
endinterface

// single-cycle line transfer, no back-pressure
interface line_xfer_if;
    logic                       valid;
    logic [`LINE_ADDR_BITS-1:0] line_addr;
    logic [`BLK_BITS-1:0]       block;
    logic                       dirty;

    modport source (output valid, line_addr, block, dirty);
    modport sink   (input valid, line_addr, block, dirty);
endinterface

//--- verilog/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    // one line seen at three access widths
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } cache_block_t;

    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef enum logic [1:0] {CMD_NONE, CMD_LOAD, CMD_STORE} mem_cmd_e;

    typedef enum logic [1:0] {ST_READY, ST_WAIT_MEM, ST_REPLAY} ctrl_state_e;

    // place write data into a line by size and byte offset
    function automatic cache_block_t store_merge(input cache_block_t blk,
                                                 input mem_size_e size,
                                                 input logic [`BLK_OFS-1:0] ofs,
                                                 input logic [`XLEN-1:0] wdata);
        cache_block_t res;
        res = blk;
        case (size)
            SIZE_BYTE: res.bytes[ofs] = wdata[7:0];
            SIZE_HALF: res.halves[ofs[2:1]] = wdata[15:0];
            default:   res.words[ofs[2]] = wdata;
        endcase
        return res;
    endfunction

    // zero-extended read of the addressed bytes
    function automatic logic [`XLEN-1:0] load_extract(input cache_block_t blk,
                                                      input mem_size_e size,
                                                      input logic [`BLK_OFS-1:0] ofs);
        logic [`XLEN-1:0] res;
        case (size)
            SIZE_BYTE: res = {24'b0, blk.bytes[ofs]};
            SIZE_HALF: res = {16'b0, blk.halves[ofs[2:1]]};
            default:   res = blk.words[ofs[2]];
        endcase
        return res;
    endfunction

endpackage

//--- include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and data path
`define XLEN 32

// line geometry, 8-byte lines
`define BLK_BITS 64
`define BLK_OFS 3

// direct-mapped main cache
`define N_CL 16
`define IDX_BITS 4
`define TAG_BITS (`XLEN - `IDX_BITS - `BLK_OFS)
`define LINE_ADDR_BITS (`XLEN - `BLK_OFS)

// victim cache and its lru counters
`define N_VC 4
`define LRU_BITS 2

// miss status table and memory tags
`define N_MSHR 4
`define MEM_TAG_BITS 4

`endif
